//--- source/sme_pkg.sv
// Data width, opcode enum, command struct, register map and latency for the masked ALU
`default_nettype none

package sme_pkg;

    localparam int XLEN        = 32;       // Data word width
    localparam int SME_LATENCY = 3;        // Cmd ack to done, in cycles

    // --------------------
    // Operation codes
    // --------------------

    typedef enum logic [2:0] {
        OP_XOR    = 3'd0,
        OP_XNOR   = 3'd1,
        OP_AND    = 3'd2,                  // DOM
        OP_OR     = 3'd3,                  // DOM, share 0 inverted around it
        OP_ANDN   = 3'd4,                  // DOM, share 0 of b inverted
        OP_SHIFT  = 3'd5,
        OP_ROTATE = 3'd6
    } sme_op_e;

    // One command as written to REG_CMD, low bits of the bus word
    typedef struct packed {
        sme_op_e    op;                    // Bits 8:6
        logic [4:0] shamt;                 // Bits 5:1, shift/rotate amount
        logic       left;                  // Bit 0, 1 = left, 0 = right
    } sme_cmd_t;

    // --------------------
    // Register map
    // --------------------

    // Word addresses
    localparam logic [3:0] REG_RS1    = 4'd0;   // WO
    localparam logic [3:0] REG_RS2    = 4'd1;   // WO
    localparam logic [3:0] REG_CMD    = 4'd2;   // WO, starts the op
    localparam logic [3:0] REG_STATUS = 4'd3;   // RO, bit 0 busy
    localparam logic [3:0] REG_RESULT = 4'd4;   // RO, unmasked result
    localparam logic [3:0] REG_SHARE0 = 4'd8;   // RO, share i at 8+i

endpackage

`default_nettype wire

//--- source/sme_rng.sv
// LFSR bank supplying every random word the masked datapath needs in one cycle
`default_nettype none

module sme_rng #(
    parameter  int SHARES = 3,                                  // Number of Boolean shares
    localparam int NRAND  = (SHARES - 1) + SHARES * (SHARES - 1) / 2
)(
    input  logic                              g_clk,           // Global clock
    input  logic                              reset,           // Sync, active high
    output logic [NRAND*sme_pkg::XLEN-1:0]    rand_words       // Flat, word k at k*XLEN
);

    import sme_pkg::*;

    // Feedback mask for the right-shifting Galois form
    localparam logic [XLEN-1:0] TAPS = 32'h8020_0003;

    logic [XLEN-1:0] lfsr [NRAND];

    // Distinct, never zero: odd multiplier times a nonzero index
    function automatic logic [XLEN-1:0] seed_of(input int k);
        logic [XLEN-1:0] idx;
        idx = XLEN'(k + 1);
        return idx * 32'h9E37_79B9;
    endfunction

    // --------------------
    // Step all LFSRs
    // --------------------

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int k = 0; k < NRAND; k++) begin
                lfsr[k] <= seed_of(k);
            end
        end else begin
            for (int k = 0; k < NRAND; k++) begin
                lfsr[k] <= {1'b0, lfsr[k][XLEN-1:1]} ^ (lfsr[k][0] ? TAPS : '0);
            end
        end
    end

    // Flatten for the port
    always_comb begin
        for (int k = 0; k < NRAND; k++) begin
            rand_words[k*XLEN +: XLEN] = lfsr[k];
        end
    end

endmodule

`default_nettype wire

//--- source/sme_share_split.sv
// Feeder turning the two plain operands into registered Boolean shares
`default_nettype none

module sme_share_split #(
    parameter  int SHARES = 3,
    localparam int NRAND  = (SHARES - 1) + SHARES * (SHARES - 1) / 2
)(
    input  logic                              g_clk,
    input  logic                              reset,
    input  logic                              start,           // Op launch pulse
    input  logic [31:0]                       rs1,             // Plain operand a
    input  logic [31:0]                       rs2,             // Plain operand b
    input  logic [NRAND*sme_pkg::XLEN-1:0]    rand_words,
    output logic                              split_valid,     // One cycle after start
    output logic [SHARES*sme_pkg::XLEN-1:0]   a_shares,
    output logic [SHARES*sme_pkg::XLEN-1:0]   b_shares
);

    import sme_pkg::*;

    logic [XLEN-1:0]        mask_all;      // XOR of the splitting words
    logic [SHARES*XLEN-1:0] a_next;
    logic [SHARES*XLEN-1:0] b_next;

    // --------------------
    // Share generation
    // --------------------

    always_comb begin
        mask_all = '0;
        for (int i = 1; i < SHARES; i++) begin
            mask_all = mask_all ^ rand_words[(i-1)*XLEN +: XLEN];
        end

        // Share 0 carries the plain value under all masks
        a_next[0 +: XLEN] = rs1 ^ mask_all;
        b_next[0 +: XLEN] = rs2 ^ mask_all;

        // Higher shares are the splitting words themselves
        for (int i = 1; i < SHARES; i++) begin
            a_next[i*XLEN +: XLEN] = rand_words[(i-1)*XLEN +: XLEN];
            b_next[i*XLEN +: XLEN] = rand_words[(i-1)*XLEN +: XLEN];
        end
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            split_valid <= 1'b0;
        end else begin
            split_valid <= start;
        end
    end

    // Share registers, loaded once per op
    always_ff @(posedge g_clk) begin
        if (start) begin
            a_shares <= a_next;
            b_shares <= b_next;
        end
    end

endmodule

`default_nettype wire

//--- source/sme_share_lane.sv
// One share domain: linear ops, shift/rotate and its slice of the DOM AND
`default_nettype none

module sme_share_lane #(
    parameter  int SHARES = 3,
    parameter  int LANE   = 0,                                  // Share index of this domain
    localparam int NRAND  = (SHARES - 1) + SHARES * (SHARES - 1) / 2
)(
    input  logic                              g_clk,
    input  logic                              reset,
    input  logic                              in_valid,        // From the feeder
    input  sme_pkg::sme_cmd_t                 cmd,
    input  logic [31:0]                       a_share,         // Own share of a
    input  logic [SHARES*sme_pkg::XLEN-1:0]   b_shares,        // All shares of b
    input  logic [NRAND*sme_pkg::XLEN-1:0]    rand_words,
    output logic [31:0]                       res_share,
    output logic                              out_valid
);

    import sme_pkg::*;

    localparam bit IS_ZERO = (LANE == 0);  // Share 0 takes the inversions

    // Word index of r_ij for i < j, after the splitting words
    function automatic int pair_word(input int i, input int j);
        int idx;
        idx = SHARES - 1;
        for (int k = 0; k < i; k++) begin
            idx += SHARES - 1 - k;
        end
        return idx + (j - i - 1);
    endfunction

    logic [XLEN-1:0]   a_eff;              // a after OR inversion
    logic [XLEN-1:0]   b_own;
    logic [XLEN-1:0]   dom_res;            // DOM AND slice
    logic [XLEN-1:0]   shift_res;
    logic [XLEN-1:0]   lane_res;

    // --------------------
    // DOM AND slice
    // --------------------

    always_comb begin
        logic            inv_b;
        logic [XLEN-1:0] b_j;
        int              lo;
        int              hi;

        inv_b = (cmd.op == OP_OR) || (cmd.op == OP_ANDN);
        a_eff = (IS_ZERO && cmd.op == OP_OR) ? ~a_share : a_share;
        b_own = b_shares[LANE*XLEN +: XLEN];

        // Inner domain term
        b_j     = (IS_ZERO && inv_b) ? ~b_own : b_own;
        dom_res = a_eff & b_j;

        // Cross-domain terms, each blinded by the pair word
        for (int j = 0; j < SHARES; j++) begin
            if (j != LANE) begin
                lo  = (j < LANE) ? j : LANE;
                hi  = (j < LANE) ? LANE : j;
                b_j = b_shares[j*XLEN +: XLEN];
                if (j == 0 && inv_b) begin
                    b_j = ~b_j;    // Share 0 of b inverted
                end
                dom_res = dom_res ^ (a_eff & b_j) ^ rand_words[pair_word(lo, hi)*XLEN +: XLEN];
            end
        end
    end

    // --------------------
    // Shift and rotate
    // --------------------

    always_comb begin
        logic [2*XLEN-1:0] dbl;
        logic [XLEN-1:0]   fill;

        fill = (cmd.op == OP_ROTATE) ? a_share : '0;   // Zero fill stays linear
        if (cmd.left) begin
            dbl       = {a_share, fill} << cmd.shamt;
            shift_res = dbl[2*XLEN-1:XLEN];
        end else begin
            dbl       = {fill, a_share} >> cmd.shamt;
            shift_res = dbl[XLEN-1:0];
        end
    end

    // Result select
    always_comb begin
        case (cmd.op)
            OP_XOR:    lane_res = a_share ^ b_own;
            OP_XNOR:   lane_res = IS_ZERO ? ~(a_share ^ b_own) : (a_share ^ b_own);
            OP_AND,
            OP_ANDN:   lane_res = dom_res;
            OP_OR:     lane_res = IS_ZERO ? ~dom_res : dom_res;    // De Morgan
            OP_SHIFT,
            OP_ROTATE: lane_res = shift_res;
            default:   lane_res = '0;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_valid) begin
            res_share <= lane_res;     // Register ends the glitch path
        end
    end

endmodule

`default_nettype wire

//--- source/sme_share_join.sv
// Drain holding the result shares and recombining them into the plain result
`default_nettype none

module sme_share_join #(
    parameter int SHARES = 3
)(
    input  logic                              g_clk,
    input  logic                              reset,
    input  logic                              in_valid,        // All lanes valid
    input  logic [SHARES*sme_pkg::XLEN-1:0]   lane_shares,
    output logic [SHARES*sme_pkg::XLEN-1:0]   res_shares,      // For readback
    output logic [31:0]                       result,          // Unmasked
    output logic                              done
);

    import sme_pkg::*;

    logic [XLEN-1:0] unmasked;

    // --------------------
    // Unmask
    // --------------------

    // Only place where the shares meet
    always_comb begin
        unmasked = '0;
        for (int i = 0; i < SHARES; i++) begin
            unmasked = unmasked ^ lane_shares[i*XLEN +: XLEN];
        end
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            done       <= 1'b0;
            res_shares <= '0;
            result     <= '0;
        end else begin
            done <= in_valid;                  // One-cycle pulse
            if (in_valid) begin
                res_shares <= lane_shares;
                result     <= unmasked;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sme_wb_ctrl.sv
// Wishbone classic slave with operand and command registers, busy flag and readback mux
`default_nettype none

module sme_wb_ctrl #(
    parameter int SHARES = 3
)(
    input  logic                              g_clk,
    input  logic                              reset,
    // Wishbone slave
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [3:0]                        adr,             // Word address
    input  logic [31:0]                       dat_w,
    output logic                              ack,
    output logic [31:0]                       dat_r,
    // Datapath side
    input  logic                              done,            // From the drain
    input  logic [31:0]                       result,
    input  logic [SHARES*sme_pkg::XLEN-1:0]   res_shares,
    output logic                              start,           // One cycle, with ack
    output logic [31:0]                       rs1,
    output logic [31:0]                       rs2,
    output sme_pkg::sme_cmd_t                 cmd
);

    import sme_pkg::*;

    logic             busy;                // Op in flight
    logic             access;              // New bus cycle seen
    logic             wr_ok;               // Write that may land
    logic [3:0]       share_sel;
    logic [XLEN-1:0]  read_word;

    // --------------------
    // Bus decode
    // --------------------

    assign access    = cyc && stb && !ack;         // Ack low, so not the same cycle twice
    assign wr_ok     = access && we && !busy;      // Operand writes locked while busy
    assign share_sel = adr - REG_SHARE0;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            ack   <= access;                       // Exactly one cycle
            start <= wr_ok && (adr == REG_CMD);
            if (wr_ok && adr == REG_CMD) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Operand and command registers, latched with ack
    always_ff @(posedge g_clk) begin
        if (wr_ok) begin
            case (adr)
                REG_RS1: rs1 <= dat_w;
                REG_RS2: rs2 <= dat_w;
                REG_CMD: cmd <= sme_cmd_t'(dat_w[$bits(sme_cmd_t)-1:0]);
                default: ;                         // Unmapped or read only
            endcase
        end
    end

    // --------------------
    // Readback
    // --------------------

    always_comb begin
        read_word = '0;                            // Unmapped reads as zero
        case (adr)
            REG_STATUS: read_word = {{(XLEN-1){1'b0}}, busy};
            REG_RESULT: read_word = result;
            default: begin
                if (adr >= REG_SHARE0 && int'(share_sel) < SHARES) begin
                    read_word = res_shares[share_sel*XLEN +: XLEN];
                end
            end
        endcase
    end

    // Valid while ack high
    always_ff @(posedge g_clk) begin
        dat_r <= (access && !we) ? read_word : '0;
    end

endmodule

`default_nettype wire

//--- source/sme_alu_top.sv
// Top level joining bus controller, rng, feeder, share lanes and drain
`default_nettype none

module sme_alu_top #(
    parameter int SHARES = 3                   // 2 to 8
)(
    input  logic        g_clk,                 // Global clock
    input  logic        reset,                 // Sync, active high
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    import sme_pkg::*;

    localparam int NRAND = (SHARES - 1) + SHARES * (SHARES - 1) / 2;

    if (SHARES < 2 || SHARES > 8) begin : g_bad_shares
        $error("SHARES must be in 2..8");      // Share readback has 8 slots
    end

    logic                    start;
    logic [XLEN-1:0]         rs1;
    logic [XLEN-1:0]         rs2;
    sme_cmd_t                cmd;
    logic [NRAND*XLEN-1:0]   rand_words;
    logic                    split_valid;
    logic [SHARES*XLEN-1:0]  a_shares;
    logic [SHARES*XLEN-1:0]  b_shares;
    logic [SHARES-1:0]       lane_valid_v;
    logic                    lane_valid;
    logic [SHARES*XLEN-1:0]  lane_shares;
    logic [SHARES*XLEN-1:0]  res_shares;
    logic [XLEN-1:0]         result;
    logic                    done;

    // --------------------
    // Control and masking
    // --------------------

    sme_wb_ctrl #(.SHARES(SHARES)) i_ctrl (
        .g_clk(g_clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .ack(ack), .dat_r(dat_r),
        .done(done), .result(result), .res_shares(res_shares),
        .start(start), .rs1(rs1), .rs2(rs2), .cmd(cmd)
    );

    sme_rng #(.SHARES(SHARES)) i_rng (
        .g_clk(g_clk), .reset(reset), .rand_words(rand_words)
    );

    sme_share_split #(.SHARES(SHARES)) i_split (
        .g_clk(g_clk), .reset(reset), .start(start), .rs1(rs1), .rs2(rs2),
        .rand_words(rand_words), .split_valid(split_valid),
        .a_shares(a_shares), .b_shares(b_shares)
    );

    // One lane per share domain
    for (genvar l = 0; l < SHARES; l++) begin : g_lanes
        sme_share_lane #(.SHARES(SHARES), .LANE(l)) i_lane (
            .g_clk(g_clk), .reset(reset), .in_valid(split_valid), .cmd(cmd),
            .a_share(a_shares[l*XLEN +: XLEN]), .b_shares(b_shares),
            .rand_words(rand_words),
            .res_share(lane_shares[l*XLEN +: XLEN]), .out_valid(lane_valid_v[l])
        );
    end

    assign lane_valid = &lane_valid_v;         // Lanes run in lockstep

    sme_share_join #(.SHARES(SHARES)) i_join (
        .g_clk(g_clk), .reset(reset), .in_valid(lane_valid), .lane_shares(lane_shares),
        .res_shares(res_shares), .result(result), .done(done)
    );

endmodule

`default_nettype wire

//--- tb/sme_alu_asserts.sv
// Bound concurrent checks on bus handshake, fixed latency, busy lockout and share recombination
`default_nettype none

module sme_alu_asserts #(
    parameter int SHARES = 3
)(
    input  logic                              g_clk,
    input  logic                              reset,
    input  logic                              ack,
    input  logic                              start,
    input  logic                              busy,            // Controller flag
    input  logic                              done,
    input  logic [31:0]                       result,
    input  logic [SHARES*sme_pkg::XLEN-1:0]   res_shares
);

    timeunit 1ns;
    timeprecision 100ps;

    import sme_pkg::*;

    int              failures = 0;         // Polled by the testbench
    logic [XLEN-1:0] share_xor;

    always_comb begin
        share_xor = '0;
        for (int i = 0; i < SHARES; i++) begin
            share_xor = share_xor ^ res_shares[i*XLEN +: XLEN];
        end
    end

    // --------------------
    // Handshake and timing
    // --------------------

    ack_single: assert property (@(posedge g_clk) disable iff (reset) $past(ack) |-> !ack)
        else begin failures++; $error("ack stayed high for two cycles"); end

    done_on_time: assert property (@(posedge g_clk) disable iff (reset)
        $past(start, SME_LATENCY) |-> done)
        else begin failures++; $error("done missing SME_LATENCY cycles after start"); end

    done_only_after_start: assert property (@(posedge g_clk) disable iff (reset)
        done |-> $past(start, SME_LATENCY))
        else begin failures++; $error("done without a start SME_LATENCY cycles before"); end

    start_when_idle: assert property (@(posedge g_clk) disable iff (reset)
        start |-> !$past(busy))
        else begin failures++; $error("start raised while an op was in flight"); end

    // Shares must recombine to the plain word
    shares_match: assert property (@(posedge g_clk) disable iff (reset)
        done |-> (share_xor == result))
        else begin failures++; $error("XOR of result shares differs from result"); end

endmodule

`default_nettype wire

//--- tb/sme_alu_tb.sv
// Testbench for the masked ALU: clock, reset, Wishbone tasks, reference model, op sequences, watchdog
`default_nettype none

module sme_alu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import sme_pkg::*;

    localparam int SHARES      = 3;
    localparam int WATCHDOG_NS = 60 * 40 * 20;   // Ops x cycles per op x period

    logic        g_clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic [31:0] exp_res;                  // Expected plain result of the current op

    sme_alu_top #(.SHARES(SHARES)) sme_alu_top_inst (
        .g_clk(g_clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    bind sme_alu_top sme_alu_asserts #(.SHARES(SHARES)) asserts_inst (
        .g_clk(g_clk), .reset(reset), .ack(ack), .start(start), .busy(i_ctrl.busy),
        .done(done), .result(result), .res_shares(res_shares)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;        // 20 ns period
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic abort_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, why);
    endtask

    // Plain result straight from the operation rules
    function automatic logic [31:0] ref_result(input sme_op_e op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [4:0] sh,
                                               input logic left);
        logic [5:0] back;
        back = 6'd32 - {1'b0, sh};
        case (op)
            OP_XOR:    return a ^ b;
            OP_XNOR:   return ~(a ^ b);
            OP_AND:    return a & b;
            OP_OR:     return a | b;
            OP_ANDN:   return a & ~b;
            OP_SHIFT:  return left ? (a << sh) : (a >> sh);
            OP_ROTATE: begin
                if (sh == 5'd0) return a;  // Avoid a 32-bit shift
                return left ? ((a << sh) | (a >> back)) : ((a >> sh) | (a << back));
            end
            default:   return '0;
        endcase
    endfunction

    function automatic logic [31:0] cmd_word(input sme_op_e op, input logic [4:0] sh,
                                             input logic left);
        sme_cmd_t c;
        c.op    = op;
        c.shamt = sh;
        c.left  = left;
        return 32'(c);
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run("read value mismatch");
        end
    endtask

    // One classic cycle, driven on rising edges and sampled on falling ones
    task automatic bus_cycle(input logic [3:0] a, input logic wr, input logic [31:0] d,
                             output logic [31:0] q);
        @(posedge g_clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        do @(negedge g_clk); while (!ack);
        q = dat_r;                         // Valid while ack high
        @(posedge g_clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_cycle(a, 1'b1, d, unused);
    endtask

    task automatic wb_read(input logic [3:0] a, output logic [31:0] q);
        bus_cycle(a, 1'b0, 32'd0, q);
    endtask

    // Poll STATUS until busy drops, bounded
    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        status = 32'd1;
        polls  = 0;
        while (status[0]) begin
            wb_read(REG_STATUS, status);
            polls++;
            assert (polls < 8 || !status[0]) else begin
                $display("Error at %0t ns: busy did not clear after a command", $time);
                abort_run("busy stuck high");
            end
        end
        check_word("STATUS after completion", status, 32'd0);
    endtask

    task automatic start_op(input sme_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input logic [4:0] sh, input logic left);
        exp_res = ref_result(op, a, b, sh, left);
        wb_write(REG_RS1, a);
        wb_write(REG_RS2, b);
        wb_write(REG_CMD, cmd_word(op, sh, left));
    endtask

    // Result and every share read back, shares folded by XOR
    task automatic finish_op(output logic [31:0] share0);
        logic [31:0] word;
        logic [31:0] folded;
        folded = '0;
        wait_idle();
        wb_read(REG_RESULT, word);
        check_word("RESULT", word, exp_res);
        for (int i = 0; i < SHARES; i++) begin
            wb_read(REG_SHARE0 + 4'(i), word);
            if (i == 0) share0 = word;
            folded ^= word;
        end
        check_word("XOR of shares", folded, exp_res);
    endtask

    task automatic run_op(input sme_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] sh, input logic left, output logic [31:0] share0);
        start_op(op, a, b, sh, left);
        finish_op(share0);
    endtask

    // Watchdog
    initial begin
        #WATCHDOG_NS;
        abort_run("timeout, the run did not finish in the allowed time");
    end

    // Bound assertion failures end the run
    initial begin
        wait (sme_alu_top_inst.asserts_inst.failures != 0);
        abort_run("a bound assertion failed");
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s0_first;
        logic [31:0] s0_next;
        logic [31:0] pat_a [3];
        logic [31:0] pat_b [3];
        logic [4:0]  amounts [4];
        sme_op_e     nl_ops [3];
        sme_op_e     sr_op;

        void'($urandom(71));
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = 4'd0;
        dat_w = 32'd0;
        repeat (2) @(posedge g_clk);
        reset <= 1'b0;

        wb_read(REG_STATUS, word);
        check_word("STATUS after reset", word, 32'd0);

        // Linear ops, directed then random
        pat_a = '{32'h0000_0000, 32'hFFFF_FFFF, 32'hAAAA_AAAA};
        pat_b = '{32'h0000_0000, 32'hAAAA_AAAA, 32'h5555_5555};
        for (int i = 0; i < 3; i++) begin
            run_op(OP_XOR, pat_a[i], pat_b[i], 5'd0, 1'b0, s0_first);
            run_op(OP_XNOR, pat_a[i], pat_b[i], 5'd0, 1'b0, s0_first);
        end
        for (int i = 0; i < 2; i++) begin
            a = $urandom();
            b = $urandom();
            run_op(OP_XOR, a, b, 5'd0, 1'b0, s0_first);
            run_op(OP_XNOR, a, b, 5'd0, 1'b0, s0_first);
        end

        // DOM ops
        nl_ops = '{OP_AND, OP_OR, OP_ANDN};
        for (int i = 0; i < 20; i++) begin
            run_op(nl_ops[i % 3], $urandom(), $urandom(), 5'd0, 1'b0, s0_first);
        end

        // Shift and rotate, both directions
        amounts = '{5'd0, 5'd1, 5'd31, 5'd0};
        for (int s = 0; s < 2; s++) begin
            sr_op = (s == 0) ? OP_SHIFT : OP_ROTATE;
            for (int l = 0; l < 2; l++) begin
                for (int k = 0; k < 4; k++) begin
                    amounts[3] = 5'($urandom());
                    run_op(sr_op, $urandom(), 32'd0, amounts[k], 1'(l), s0_first);
                end
            end
        end

        // Same operands twice, fresh masks
        a = $urandom();
        b = $urandom();
        run_op(OP_AND, a, b, 5'd0, 1'b0, s0_first);
        run_op(OP_AND, a, b, 5'd0, 1'b0, s0_next);
        assert (s0_next != s0_first) else begin
            $display("Error at %0t ns: share 0 repeated 0x%08h for a rerun", $time, s0_next);
            abort_run("masking not refreshed");
        end

        // Writes while busy must not land
        start_op(OP_XOR, a, b, 5'd0, 1'b0);
        wb_write(REG_RS1, ~a);
        finish_op(s0_first);
        wb_write(REG_CMD, cmd_word(OP_XOR, 5'd0, 1'b0));    // Still uses the old rs1
        finish_op(s0_first);
        start_op(OP_AND, a, b, 5'd0, 1'b0);
        wb_write(REG_CMD, cmd_word(OP_OR, 5'd0, 1'b0));
        finish_op(s0_first);

        // Unmapped words read as zero
        wb_write(4'd5, 32'hDEAD_BEEF);
        for (int k = 5; k < 16; k++) begin
            if (k < 8 || k >= 8 + SHARES) begin
                wb_read(4'(k), word);
                check_word("unmapped address", word, 32'd0);
            end
        end

        if (sme_alu_top_inst.asserts_inst.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- tb.f
source/sme_pkg.sv
source/sme_rng.sv
source/sme_share_split.sv
source/sme_share_lane.sv
source/sme_share_join.sv
source/sme_wb_ctrl.sv
source/sme_alu_top.sv
tb/sme_alu_asserts.sv
tb/sme_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the masked ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module sme_alu_tb --Mdir obj_dir -o sme_alu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

# Let bound assertion errors reach the testbench, which then stops with $fatal
./obj_dir/sme_alu_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0
